// File: common/mp_pkg.sv
package mp_pkg;

    // Sample and frame geometry
    parameter int SAMPLE_W     = 16;
    parameter int NUM_SAMPLES  = 16;
    parameter int SAMPLE_SHIFT = 4;

    // Dictionary
    parameter int NUM_ATOMS  = 32;
    parameter int ATOM_IDX_W = 5;

    // Iterations per frame
    parameter int NUM_ITERS = 4;
    parameter int ITER_W    = 2;

    // Correlation grows by log2 of the frame length
    parameter int CORR_W = SAMPLE_W + SAMPLE_SHIFT;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t [NUM_SAMPLES-1:0] smp;
    } frame_t;

    // One bit per sample, set means minus one
    typedef logic [NUM_SAMPLES-1:0] atom_t;

    typedef struct packed {
        logic [ATOM_IDX_W-1:0] atom_idx;
        sample_t               coef;
        logic [ITER_W-1:0]     iter;
        logic                  last;
    } result_t;

endpackage

// File: verilog/sample_loader.sv
`timescale 1ns/1ps

module sample_loader (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  mp_pkg::sample_t in_sample,
    output logic            in_credit,
    output logic            frame_valid,
    output mp_pkg::frame_t  frame,
    input  logic            frame_take
);

    localparam int CNT_W = $clog2(mp_pkg::NUM_SAMPLES);
    localparam int RET_W = $clog2(mp_pkg::NUM_SAMPLES + 1);

    logic [CNT_W-1:0] wr_cnt;
    logic [RET_W-1:0] ret_cnt;
    logic             last_sample;

    assign last_sample = (wr_cnt == CNT_W'(mp_pkg::NUM_SAMPLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_cnt      <= '0;
            frame_valid <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_cnt <= last_sample ? '0 : wr_cnt + 1'b1;
            end
            if (in_valid && last_sample) begin
                frame_valid <= 1'b1;
            end else if (frame_take) begin
                frame_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            frame.smp[wr_cnt] <= in_sample;
        end
    end

    // Whole frame of credits goes back once the engine has its copy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ret_cnt <= '0;
        end else if (frame_take) begin
            ret_cnt <= RET_W'(mp_pkg::NUM_SAMPLES);
        end else if (ret_cnt != '0) begin
            ret_cnt <= ret_cnt - 1'b1;
        end
    end

    assign in_credit = (ret_cnt != '0);

endmodule

// File: pursuit/atom_rom.sv
`timescale 1ns/1ps

module atom_rom (
    input  logic                          clk,
    input  logic [mp_pkg::ATOM_IDX_W-1:0] addr,
    output mp_pkg::atom_t                 atom
);

    mp_pkg::atom_t mem [mp_pkg::NUM_ATOMS];

    // Sign dictionary, one hex word per atom
    initial begin
        $readmemh("pursuit/dictionary.mem", mem);
    end

    always_ff @(posedge clk) begin
        atom <= mem[addr];
    end

endmodule

// File: pursuit/atom_search.sv
`timescale 1ns/1ps

module atom_search (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             search_start,
    input  mp_pkg::frame_t                   residual,
    output logic                             search_done,
    output logic [mp_pkg::ATOM_IDX_W-1:0]    best_idx,
    output logic signed [mp_pkg::CORR_W-1:0] best_corr,
    output mp_pkg::atom_t                    best_atom
);

    localparam int IDX_W  = mp_pkg::ATOM_IDX_W;
    localparam int CORR_W = mp_pkg::CORR_W;

    logic                     run;
    logic [IDX_W-1:0]         idx;
    mp_pkg::atom_t            rom_atom;
    logic                     v1;
    logic                     l1;
    logic [IDX_W-1:0]         idx1;
    logic                     v2;
    logic                     l2;
    logic [IDX_W-1:0]         idx2;
    mp_pkg::atom_t            atom2;
    logic signed [CORR_W-1:0] term;
    logic signed [CORR_W-1:0] corr_sum;
    logic signed [CORR_W-1:0] corr;
    logic [CORR_W-1:0]        corr_abs;
    logic [CORR_W-1:0]        best_abs;

    atom_rom u_rom (
        .clk  (clk),
        .addr (idx),
        .atom (rom_atom)
    );

    // Stage 0: one atom index per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run <= 1'b0;
            idx <= '0;
        end else if (search_start) begin
            run <= 1'b1;
            idx <= '0;
        end else if (run) begin
            idx <= idx + 1'b1;
            if (idx == IDX_W'(mp_pkg::NUM_ATOMS - 1)) begin
                run <= 1'b0;
            end
        end
    end

    always_comb begin
        corr_sum = '0;
        for (int i = 0; i < mp_pkg::NUM_SAMPLES; i++) begin
            term     = $signed(residual.smp[i]);
            corr_sum = rom_atom[i] ? corr_sum - term : corr_sum + term;
        end
    end

    assign corr_abs = corr[CORR_W-1] ? -corr : corr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v1          <= 1'b0;
            l1          <= 1'b0;
            v2          <= 1'b0;
            l2          <= 1'b0;
            search_done <= 1'b0;
        end else begin
            v1          <= run;
            l1          <= run && (idx == IDX_W'(mp_pkg::NUM_ATOMS - 1));
            v2          <= v1;
            l2          <= l1;
            search_done <= l2;
        end
    end

    // Stages 1 and 2 carry index and signs beside the correlation
    always_ff @(posedge clk) begin
        idx1  <= idx;
        idx2  <= idx1;
        atom2 <= rom_atom;
        corr  <= corr_sum;
    end

    // Stage 3: atom 0 seeds the search, ties keep the lower index
    always_ff @(posedge clk) begin
        if (v2 && ((idx2 == '0) || (corr_abs > best_abs))) begin
            best_abs  <= corr_abs;
            best_idx  <= idx2;
            best_corr <= corr;
            best_atom <= atom2;
        end
    end

endmodule

// File: pursuit/pursuit_engine.sv
`timescale 1ns/1ps

module pursuit_engine #(
    parameter int NUM_ITERS = mp_pkg::NUM_ITERS
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            frame_valid,
    input  mp_pkg::frame_t  frame,
    output logic            frame_take,
    output logic            res_push,
    output mp_pkg::result_t res_data,
    input  logic            res_full
);

    localparam int ITER_W = mp_pkg::ITER_W;

    typedef enum logic [1:0] {
        s_load,
        s_search,
        s_update,
        s_push
    } state_t;

    state_t                           state;
    logic [ITER_W-1:0]                iter;
    logic                             last_iter;
    mp_pkg::frame_t                   residual;
    logic                             search_start;
    logic                             search_done;
    logic [mp_pkg::ATOM_IDX_W-1:0]    best_idx;
    logic signed [mp_pkg::CORR_W-1:0] best_corr;
    mp_pkg::atom_t                    best_atom;
    mp_pkg::sample_t                  coef;

    assign frame_take = (state == s_load) && frame_valid;
    assign res_push   = (state == s_push) && !res_full;
    assign last_iter  = (iter == ITER_W'(NUM_ITERS - 1));

    // Search samples the residual two cycles after start, by then it is loaded
    assign search_start = frame_take || (res_push && !last_iter);

    // Divide by the atom norm
    assign coef = mp_pkg::sample_t'(best_corr >>> mp_pkg::SAMPLE_SHIFT);

    atom_search u_search (
        .clk          (clk),
        .rst          (rst),
        .search_start (search_start),
        .residual     (residual),
        .search_done  (search_done),
        .best_idx     (best_idx),
        .best_corr    (best_corr),
        .best_atom    (best_atom)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= s_load;
            iter  <= '0;
        end else begin
            case (state)
                s_load: begin
                    if (frame_valid) begin
                        state <= s_search;
                        iter  <= '0;
                    end
                end
                s_search: begin
                    if (search_done) begin
                        state <= s_update;
                    end
                end
                s_update: begin
                    state <= s_push;
                end
                s_push: begin
                    if (!res_full) begin
                        if (last_iter) begin
                            state <= s_load;
                        end else begin
                            state <= s_search;
                            iter  <= iter + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= s_load;
                end
            endcase
        end
    end

    // Residual update wraps to the sample width
    always_ff @(posedge clk) begin
        if (frame_take) begin
            residual <= frame;
        end else if (state == s_update) begin
            for (int i = 0; i < mp_pkg::NUM_SAMPLES; i++) begin
                if (best_atom[i]) begin
                    residual.smp[i] <= residual.smp[i] + coef;
                end else begin
                    residual.smp[i] <= residual.smp[i] - coef;
                end
            end
            res_data.atom_idx <= best_idx;
            res_data.coef     <= coef;
            res_data.iter     <= iter;
            res_data.last     <= last_iter;
        end
    end

endmodule

// File: verilog/result_sender.sv
`timescale 1ns/1ps

module result_sender #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            res_push,
    input  mp_pkg::result_t res_data,
    output logic            res_full,
    input  logic            out_credit,
    output logic            out_valid,
    output mp_pkg::result_t out_result
);

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    // Room for up to 255 outstanding grants
    localparam int CRED_W = 8;

    mp_pkg::result_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic              send;

    assign res_full = (count == CNT_W'(FIFO_DEPTH));
    assign send     = (count != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (res_push) begin
            mem[wr_ptr] <= res_data;
        end
        if (send) begin
            out_result <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (res_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({res_push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            out_valid <= send;
        end
    end

endmodule

// File: verilog/mp_top.sv
`timescale 1ns/1ps

module mp_top #(
    parameter int NUM_ITERS  = mp_pkg::NUM_ITERS,
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  mp_pkg::sample_t in_sample,
    output logic            in_credit,
    input  logic            out_credit,
    output logic            out_valid,
    output mp_pkg::result_t out_result
);

    logic            frame_valid;
    mp_pkg::frame_t  frame;
    logic            frame_take;
    logic            res_push;
    mp_pkg::result_t res_data;
    logic            res_full;

    sample_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_sample   (in_sample),
        .in_credit   (in_credit),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_take  (frame_take)
    );

    pursuit_engine #(
        .NUM_ITERS (NUM_ITERS)
    ) u_engine (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_take  (frame_take),
        .res_push    (res_push),
        .res_data    (res_data),
        .res_full    (res_full)
    );

    result_sender #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sender (
        .clk        (clk),
        .rst        (rst),
        .res_push   (res_push),
        .res_data   (res_data),
        .res_full   (res_full),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

mp_pkg::atom_t dict [mp_pkg::NUM_ATOMS];
logic [31:0]   lcg_state = 32'd37092;

initial begin
    $readmemh("pursuit/dictionary.mem", dict);
end

// Upper half of the state has the longer period
function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

// Greedy pursuit, one expected result per iteration
task automatic predict_frame(input mp_pkg::frame_t f);
    mp_pkg::sample_t res [mp_pkg::NUM_SAMPLES];
    mp_pkg::result_t r;
    int corr;
    int mag;
    int best_abs;
    int best_corr;
    int best;
    for (int i = 0; i < mp_pkg::NUM_SAMPLES; i++) begin
        res[i] = f.smp[i];
    end
    for (int it = 0; it < NUM_ITERS; it++) begin
        best      = 0;
        best_abs  = -1;
        best_corr = 0;
        for (int a = 0; a < mp_pkg::NUM_ATOMS; a++) begin
            corr = 0;
            for (int i = 0; i < mp_pkg::NUM_SAMPLES; i++) begin
                corr = dict[a][i] ? corr - int'(res[i]) : corr + int'(res[i]);
            end
            mag = (corr < 0) ? -corr : corr;
            // Strictly greater, so ties keep the lower index
            if (mag > best_abs) begin
                best_abs  = mag;
                best_corr = corr;
                best      = a;
            end
        end
        r.atom_idx = mp_pkg::ATOM_IDX_W'(best);
        r.coef     = mp_pkg::sample_t'(best_corr >>> mp_pkg::SAMPLE_SHIFT);
        r.iter     = mp_pkg::ITER_W'(it);
        r.last     = (it == NUM_ITERS - 1);
        exp_q.push_back(r);
        for (int i = 0; i < mp_pkg::NUM_SAMPLES; i++) begin
            res[i] = dict[best][i] ? res[i] + r.coef : res[i] - r.coef;
        end
    end
endtask

`endif

// File: sim/tb_mp_top.sv
`timescale 1ns/1ps

module tb_mp_top;

    localparam int NUM_ITERS   = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int NUM_SAMPLES = mp_pkg::NUM_SAMPLES;
    localparam int ITER_CYCLES = NUM_ITERS * (mp_pkg::NUM_ATOMS + 5);
    // Fourteen frames in all, intake and credit grants added per frame
    localparam int NUM_FRAMES  = 14;
    localparam int FRAME_CYCLES = ITER_CYCLES + 3 * NUM_SAMPLES + 20;
    localparam int HOLD_CYCLES  = 2 * ITER_CYCLES + 4 * NUM_SAMPLES;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + HOLD_CYCLES + 600;

    logic            clk = 1'b0;
    logic            rst;
    logic            in_valid;
    mp_pkg::sample_t in_sample;
    logic            in_credit;
    logic            out_credit;
    logic            out_valid;
    mp_pkg::result_t out_result;

    mp_pkg::frame_t  frame_q [$];
    mp_pkg::result_t exp_q [$];
    mp_pkg::result_t rx_q [$];
    int up_credits    = NUM_SAMPLES;
    int low_credits   = NUM_SAMPLES;
    int credit_pulses = 0;
    int cycles        = 0;
    int errors        = 0;
    int checks        = 0;
    int tests         = 0;

    `include "tb_model.svh"

    mp_top #(
        .NUM_ITERS  (NUM_ITERS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, results never arrived", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (out_valid) begin
            rx_q.push_back(out_result);
        end
        if (in_credit) begin
            credit_pulses++;
            up_credits++;
            if (up_credits > NUM_SAMPLES) begin
                errors++;
                $display("ERR %0t: upstream holds %0d credits, limit is %0d",
                         $time, up_credits, NUM_SAMPLES);
            end
        end
    end

    task automatic verify_result(input mp_pkg::result_t got, input mp_pkg::result_t want,
                                 input string what);
        string got_s;
        string want_s;
        checks++;
        if (got !== want) begin
            errors++;
            got_s  = $sformatf("idx %0d coef %0d iter %0d last %0b",
                               got.atom_idx, $signed(got.coef), got.iter, got.last);
            want_s = $sformatf("idx %0d coef %0d iter %0d last %0b",
                               want.atom_idx, $signed(want.coef), want.iter, want.last);
            $display("ERR %0t: %s got %s, expected %s", $time, what, got_s, want_s);
        end
    endtask

    task automatic compare_count(input int got, input int want, input string what);
        checks++;
        if (got != want) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    function automatic mp_pkg::frame_t random_frame();
        mp_pkg::frame_t f;
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            f.smp[i] = mp_pkg::sample_t'(lcg_next());
        end
        return f;
    endfunction

    task automatic queue_frame(input mp_pkg::frame_t f);
        frame_q.push_back(f);
        predict_frame(f);
    endtask

    // Upstream spends one credit per sample
    task automatic send_queued_frames();
        mp_pkg::frame_t f;
        int i;
        while (frame_q.size() > 0) begin
            f = frame_q.pop_front();
            i = 0;
            while (i < NUM_SAMPLES) begin
                @(posedge clk);
                if (up_credits > 0) begin
                    in_valid  <= 1'b1;
                    in_sample <= f.smp[i];
                    up_credits--;
                    if (up_credits < low_credits) begin
                        low_credits = up_credits;
                    end
                    i++;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic grant_credits(input int n);
        repeat (n) begin
            @(posedge clk);
            out_credit <= 1'b1;
        end
        @(posedge clk);
        out_credit <= 1'b0;
    endtask

    task automatic wait_results(input int n);
        while (rx_q.size() < n) begin
            @(posedge clk);
        end
    endtask

    task automatic match_expected(input string what);
        while (exp_q.size() > 0) begin
            if (rx_q.size() == 0) begin
                errors++;
                $display("%s: %0d expected results never arrived", what, exp_q.size());
                exp_q.delete();
            end else begin
                verify_result(rx_q.pop_front(), exp_q.pop_front(), what);
            end
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        $display("%s: %0d errors", name, errors - mark);
    endtask

    task automatic idle_after_reset();
        int mark;
        int rx0;
        int cr0;
        mark = errors;
        rx0  = rx_q.size();
        cr0  = credit_pulses;
        repeat (50) @(posedge clk);
        compare_count(rx_q.size() - rx0, 0, "results while idle");
        compare_count(credit_pulses - cr0, 0, "input credits while idle");
        report_test("idle after reset", mark);
    endtask

    task automatic scaled_atom_frame();
        mp_pkg::frame_t  f;
        mp_pkg::result_t first;
        int mark;
        mark = errors;
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            f.smp[i] = dict[5][i] ? -16'sd8 : 16'sd8;
        end
        first.atom_idx = 5;
        first.coef     = 16'sd8;
        first.iter     = '0;
        first.last     = 1'b0;
        queue_frame(f);
        grant_credits(NUM_ITERS);
        send_queued_frames();
        wait_results(NUM_ITERS);
        verify_result(rx_q[0], first, "scaled atom, first result");
        match_expected("scaled atom");
        report_test("scaled atom frame", mark);
    endtask

    task automatic random_back_to_back();
        int mark;
        mark = errors;
        for (int n = 0; n < 8; n++) begin
            queue_frame(random_frame());
        end
        grant_credits(8 * NUM_ITERS);
        send_queued_frames();
        wait_results(8 * NUM_ITERS);
        match_expected("random frames");
        report_test("random frames back to back", mark);
    endtask

    // Two frames overfill the FIFO, so the engine stalls too
    task automatic output_backpressure();
        int mark;
        mark = errors;
        queue_frame(random_frame());
        queue_frame(random_frame());
        send_queued_frames();
        grant_credits(2);
        wait_results(2);
        repeat (HOLD_CYCLES) @(posedge clk);
        compare_count(rx_q.size(), 2, "results sent on two credits");
        grant_credits(2 * NUM_ITERS - 2);
        wait_results(2 * NUM_ITERS);
        match_expected("back-pressure");
        report_test("output back-pressure", mark);
    endtask

    task automatic input_credit_return();
        int mark;
        int cr0;
        mark        = errors;
        cr0         = credit_pulses;
        low_credits = up_credits;
        for (int n = 0; n < 3; n++) begin
            queue_frame(random_frame());
        end
        grant_credits(3 * NUM_ITERS);
        send_queued_frames();
        wait_results(3 * NUM_ITERS);
        compare_count(credit_pulses - cr0, 3 * NUM_SAMPLES, "credits returned for 3 frames");
        compare_count(up_credits, NUM_SAMPLES, "upstream credits at the end");
        compare_count(low_credits, 0, "lowest upstream credit count");
        match_expected("input credits");
        report_test("input credit return", mark);
    endtask

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_sample  = '0;
        out_credit = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        scaled_atom_frame();
        random_back_to_back();
        output_backpressure();
        input_credit_return();
        compare_count(rx_q.size(), 0, "results left over");
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: pursuit/dictionary.mem
// One 16-bit sign word per line, line n is atom n
// Bit i set means sample i is weighted by minus one
0000
5555
3333
0F0F
00FF
6996
7A3C
1E87
4B2D
2D4B
5A5A
3C3C
0FF0
6666
1234
7001
0E71
48C9
35AC
2B67
63D2
1F80
5C31
07E4
3A95
64B8
19CF
4E0D
27A6
72C3
0B5E
56F1

// File: verilog.f
+incdir+sim
common/mp_pkg.sv
verilog/sample_loader.sv
pursuit/atom_rom.sv
pursuit/atom_search.sv
pursuit/pursuit_engine.sv
verilog/result_sender.sv
verilog/mp_top.sv
sim/tb_mp_top.sv

// File: Bender.yml
package:
  name: mp_top

sources:
  - common/mp_pkg.sv
  - verilog/sample_loader.sv
  - pursuit/atom_rom.sv
  - pursuit/atom_search.sv
  - pursuit/pursuit_engine.sv
  - verilog/result_sender.sv
  - verilog/mp_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mp_top.sv
